/* common/organ_pkg.sv */
package organ_pkg;

  // ==============================
  // Data types
  // ==============================
  typedef logic        [2:0]  note_sel_t;
  typedef logic        [23:0] half_period_t;
  typedef logic signed [15:0] speed_t;
  typedef logic        [15:0] sample_count_t;
  typedef logic signed [7:0]  audio_sample_t;
  // Active low, segment a in bit 0
  typedef logic        [6:0]  seg_t;

  // ==============================
  // Constants
  // ==============================
  // Ascending scale, C5 up to C6
  localparam int NOTE_FREQ_HZ [8] = '{523, 587, 659, 698, 783, 880, 987, 1046};

  // Hex digits 0 through F
  localparam seg_t SEG_TABLE [16] = '{
    7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
    7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
    7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
    7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
  };

  localparam sample_count_t DEFAULT_SAMPLE_COUNT = 16'd12499;
  localparam speed_t        SPEED_STEP           = 16'sd100;
  localparam speed_t        MAX_SPEED            = 16'sd12000;

  localparam audio_sample_t AUDIO_HIGH = 8'sh7F;
  localparam audio_sample_t AUDIO_LOW  = 8'sh80;

  // ==============================
  // Helpers
  // ==============================
  // Clock cycles in half a tone period, truncated
  function automatic half_period_t half_period_of(input int clk_freq_hz, input note_sel_t note);
    return half_period_t'(clk_freq_hz / (2 * NOTE_FREQ_HZ[note]));
  endfunction

  // Limit to plus or minus MAX_SPEED
  function automatic speed_t clamp_speed(input int value);
    if (value > int'(MAX_SPEED))
      return MAX_SPEED;
    else if (value < -int'(MAX_SPEED))
      return speed_t'(-int'(MAX_SPEED));
    return speed_t'(value);
  endfunction

  function automatic seg_t hex_to_seg(input logic [3:0] nibble);
    return SEG_TABLE[nibble];
  endfunction

endpackage

/* common/ctrl_if.sv */
`timescale 1ns/1ps

interface ctrl_if;
  import organ_pkg::*;

  // One-cycle speed events
  logic         speed_up;
  logic         speed_down;
  // Held level while key 2 is down
  logic         speed_reset;
  half_period_t half_period;

  modport decode (
    output speed_up,
    output speed_down,
    output speed_reset,
    output half_period
  );

  modport speed (
    input speed_up,
    input speed_down,
    input speed_reset
  );

  modport tone (
    input half_period
  );

endinterface

/* decode/control_decode.sv */
`timescale 1ns/1ps

module control_decode #(
  parameter int CLK_FREQ_HZ  = 50_000_000,
  parameter int REPEAT_TICKS = 100
) (
  input  logic                 CLK_50M,
  input  logic                 reset,
  input  logic [2:0]           key,
  input  organ_pkg::note_sel_t note_sel,
  ctrl_if.decode               ctrl
);
  import organ_pkg::*;

  localparam int TICK_DIV = CLK_FREQ_HZ / 1000;
  localparam int TICK_W   = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
  localparam int WIN_W    = (REPEAT_TICKS > 1) ? $clog2(REPEAT_TICKS) : 1;

  logic [2:0]        key_meta;
  logic [2:0]        key_pressed;
  note_sel_t         note_meta;
  note_sel_t         note_sync;
  logic [TICK_W-1:0] tick_cnt;
  logic              tick_1khz;
  logic [WIN_W-1:0]  win_cnt;
  logic              win_end;
  half_period_t      hp_lut [8];

  // ==============================
  // Input synchronizers
  // ==============================
  // Keys are active low, stored here as pressed = 1
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      key_meta    <= '0;
      key_pressed <= '0;
      note_meta   <= '0;
      note_sync   <= '0;
    end
    else
    begin
      key_meta    <= ~key;
      key_pressed <= key_meta;
      note_meta   <= note_sel;
      note_sync   <= note_meta;
    end
  end

  // ==============================
  // Tick and repeat window
  // ==============================
  assign tick_1khz = (tick_cnt == TICK_W'(TICK_DIV - 1));
  assign win_end   = tick_1khz && (win_cnt == WIN_W'(REPEAT_TICKS - 1));

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      tick_cnt        <= '0;
      win_cnt         <= '0;
      ctrl.speed_up   <= 1'b0;
      ctrl.speed_down <= 1'b0;
    end
    else
    begin
      if (tick_1khz)
        tick_cnt <= '0;
      else
        tick_cnt <= tick_cnt + 1'b1;

      if (win_end)
        win_cnt <= '0;
      else if (tick_1khz)
        win_cnt <= win_cnt + 1'b1;

      // One event per window while held
      ctrl.speed_up   <= win_end & key_pressed[0];
      ctrl.speed_down <= win_end & key_pressed[1];
    end
  end

  assign ctrl.speed_reset = key_pressed[2];

  // Constant half-period per note
  for (genvar i = 0; i < 8; i++)
  begin : g_hp_lut
    assign hp_lut[i] = half_period_of(CLK_FREQ_HZ, note_sel_t'(i));
  end

  always_ff @(posedge CLK_50M)
  begin
    ctrl.half_period <= hp_lut[note_sync];
  end

  // Events are spaced at least one window apart
  a_event_spacing : assert property (@(posedge CLK_50M) disable iff (reset)
    (ctrl.speed_up || ctrl.speed_down) |=> !(ctrl.speed_up || ctrl.speed_down));

endmodule

/* execute/tone_generator.sv */
`timescale 1ns/1ps

module tone_generator (
  input  logic                     CLK_50M,
  input  logic                     reset,
  ctrl_if.tone                     ctrl,
  output organ_pkg::audio_sample_t audio_sample
);
  import organ_pkg::*;

  half_period_t hp_prev;
  half_period_t cnt;
  logic         wave;

  // ==============================
  // Half-period counter
  // ==============================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      hp_prev <= '0;
      cnt     <= '0;
      wave    <= 1'b0;
    end
    else if (ctrl.half_period != hp_prev)
    begin
      // New note, start over from low
      hp_prev <= ctrl.half_period;
      cnt     <= '0;
      wave    <= 1'b0;
    end
    else if (cnt == ctrl.half_period - 24'd1)
    begin
      cnt  <= '0;
      wave <= ~wave;
    end
    else
    begin
      cnt <= cnt + 24'd1;
    end
  end

  // Square wave as a signed sample
  assign audio_sample = wave ? AUDIO_HIGH : AUDIO_LOW;

  // Zero would stall the wave
  a_hp_nonzero : assert property (@(posedge CLK_50M) disable iff (reset)
    ctrl.half_period != '0);

endmodule

/* execute/speed_control.sv */
`timescale 1ns/1ps

module speed_control (
  input  logic                     CLK_50M,
  input  logic                     reset,
  ctrl_if.speed                    ctrl,
  output organ_pkg::sample_count_t sample_count
);
  import organ_pkg::*;

  speed_t speed;
  speed_t speed_next;

  // ==============================
  // Next speed value
  // ==============================
  // Reset key has priority over up and down
  always_comb
  begin
    if (ctrl.speed_reset)
      speed_next = '0;
    else if (ctrl.speed_up)
      speed_next = clamp_speed(int'(speed) + int'(SPEED_STEP));
    else if (ctrl.speed_down)
      speed_next = clamp_speed(int'(speed) - int'(SPEED_STEP));
    else
      speed_next = speed;
  end

  // ==============================
  // Registers
  // ==============================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      speed        <= '0;
      sample_count <= DEFAULT_SAMPLE_COUNT;
    end
    else
    begin
      speed <= speed_next;
      // Range is 499 to 24499, always fits 16 bits
      sample_count <= sample_count_t'(int'(DEFAULT_SAMPLE_COUNT) + int'(speed_next));
    end
  end

  a_speed_clamped : assert property (@(posedge CLK_50M) disable iff (reset)
    (speed <= MAX_SPEED) && (speed >= -MAX_SPEED));

endmodule

/* result/display_driver.sv */
`timescale 1ns/1ps

module display_driver #(
  parameter int DISPLAY_DIV = 25_000_000
) (
  input  logic                     CLK_50M,
  input  logic                     reset,
  input  organ_pkg::sample_count_t sample_count,
  output organ_pkg::seg_t          hex0,
  output organ_pkg::seg_t          hex1,
  output organ_pkg::seg_t          hex2,
  output organ_pkg::seg_t          hex3,
  output organ_pkg::seg_t          hex4,
  output organ_pkg::seg_t          hex5
);
  import organ_pkg::*;

  localparam int UPD_W = (DISPLAY_DIV > 1) ? $clog2(DISPLAY_DIV) : 1;

  logic [UPD_W-1:0] upd_cnt;
  logic             upd_tick;
  logic [23:0]      shown;
  seg_t             seg_q [6];

  // ==============================
  // Update tick and latch
  // ==============================
  assign upd_tick = (upd_cnt == UPD_W'(DISPLAY_DIV - 1));

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      upd_cnt <= '0;
      shown   <= '0;
    end
    else
    begin
      if (upd_tick)
        upd_cnt <= '0;
      else
        upd_cnt <= upd_cnt + 1'b1;

      // Upper byte stays zero, so hex4 and hex5 read 0
      if (upd_tick)
        shown <= {8'h00, sample_count};
    end
  end

  // ==============================
  // Segment decode
  // ==============================
  // Low nibble on hex0
  always_ff @(posedge CLK_50M)
  begin
    for (int i = 0; i < 6; i++)
    begin
      seg_q[i] <= hex_to_seg(shown[4*i +: 4]);
    end
  end

  assign hex0 = seg_q[0];
  assign hex1 = seg_q[1];
  assign hex2 = seg_q[2];
  assign hex3 = seg_q[3];
  assign hex4 = seg_q[4];
  assign hex5 = seg_q[5];

endmodule

/* hw/basic_organ.sv */
`timescale 1ns/1ps

module basic_organ #(
  parameter int CLK_FREQ_HZ  = 50_000_000,
  parameter int REPEAT_TICKS = 100,
  parameter int DISPLAY_DIV  = 25_000_000
) (
  input  logic                     CLK_50M,
  input  logic                     reset,
  // Active low push buttons
  input  logic [2:0]               key,
  input  organ_pkg::note_sel_t     note_sel,
  output organ_pkg::audio_sample_t audio_sample,
  output organ_pkg::seg_t          hex0,
  output organ_pkg::seg_t          hex1,
  output organ_pkg::seg_t          hex2,
  output organ_pkg::seg_t          hex3,
  output organ_pkg::seg_t          hex4,
  output organ_pkg::seg_t          hex5
);
  import organ_pkg::*;

  sample_count_t sample_count;

  ctrl_if u_ctrl ();

  // ==============================
  // Decode
  // ==============================
  control_decode #(
    .CLK_FREQ_HZ  (CLK_FREQ_HZ),
    .REPEAT_TICKS (REPEAT_TICKS)
  ) u_decode (
    .CLK_50M  (CLK_50M),
    .reset    (reset),
    .key      (key),
    .note_sel (note_sel),
    .ctrl     (u_ctrl.decode)
  );

  // ==============================
  // Execute
  // ==============================
  tone_generator u_tone (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .ctrl         (u_ctrl.tone),
    .audio_sample (audio_sample)
  );

  speed_control u_speed (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .ctrl         (u_ctrl.speed),
    .sample_count (sample_count)
  );

  // Readout of the sampling count
  display_driver #(
    .DISPLAY_DIV (DISPLAY_DIV)
  ) u_display (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .sample_count (sample_count),
    .hex0         (hex0),
    .hex1         (hex1),
    .hex2         (hex2),
    .hex3         (hex3),
    .hex4         (hex4),
    .hex5         (hex5)
  );

endmodule

/* tb/organ_checker.sv */
`timescale 1ns/1ps

module organ_checker (
  input  logic                     CLK_50M,
  input  logic                     reset,
  input  organ_pkg::note_sel_t     note_sel,
  input  organ_pkg::audio_sample_t audio_sample,
  input  organ_pkg::seg_t          hex [6],
  output int                       value_errors,
  output int                       other_errors
);
  import organ_pkg::*;

  localparam int KIND_RESET = 0;
  localparam int KIND_NOTE  = 1;
  localparam int KIND_UP    = 2;
  localparam int KIND_EXACT = 3;
  // Sync, lookup and restart all fit well inside this
  localparam int SETTLE_CYCLES = 8;

  // Active low with segment a in bit 0
  localparam seg_t DIGIT_SEG [16] = '{
    7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
    7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
    7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
    7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
  };

  string      row_name = "startup";
  int         row_hp = 0;
  int         row_start_measured = 0;
  int         row_value_errors = 0;
  int         row_other_errors = 0;
  int         cyc_value_errors = 0;
  int         cyc_other_errors = 0;
  int         measured = 0;
  int         cycle = 0;
  int         last_toggle = 0;
  int         settle = SETTLE_CYCLES;
  logic       have_ref = 1'b0;
  logic [7:0] audio_bits;
  logic [7:0] prev_audio = 8'h80;
  note_sel_t  prev_note = '0;

  assign audio_bits   = audio_sample;
  assign value_errors = cyc_value_errors + row_value_errors;
  assign other_errors = cyc_other_errors + row_other_errors;

  function automatic int digit_value(input seg_t seg);
    for (int i = 0; i < 16; i++)
    begin
      if (seg == DIGIT_SEG[i])
        return i;
    end
    return -1;
  endfunction

  function automatic void print_fail(input string what, input string expected, input int actual);
    $display("FAIL %s: %s expected %s, actual 0x%0h", row_name, what, expected, actual);
  endfunction

  // ==============================
  // Per-cycle checks
  // ==============================
  always @(posedge CLK_50M)
  begin
    cycle++;
    if (reset)
    begin
      settle   = SETTLE_CYCLES;
      have_ref = 1'b0;
    end
    else
    begin
      if (audio_bits != 8'h7F && audio_bits != 8'h80)
      begin
        cyc_value_errors++;
        print_fail("audio level", "0x7f or 0x80", int'(audio_bits));
      end
      for (int i = 0; i < 6; i++)
      begin
        if (digit_value(hex[i]) < 0)
        begin
          cyc_other_errors++;
          $display("%s: hex%0d shows an undecodable digit %b", row_name, i, hex[i]);
        end
        else if (i >= 4 && hex[i] != DIGIT_SEG[0])
        begin
          cyc_value_errors++;
          print_fail($sformatf("hex%0d", i), "0x0", digit_value(hex[i]));
        end
      end
      // New note restarts the wave so the old reference is void
      if (note_sel != prev_note)
      begin
        settle   = SETTLE_CYCLES;
        have_ref = 1'b0;
      end
      else if (settle > 0)
        settle--;
      else if (audio_bits != prev_audio)
      begin
        if (have_ref)
        begin
          measured++;
          if (cycle - last_toggle != row_hp)
          begin
            cyc_value_errors++;
            print_fail("half period", $sformatf("0x%0h", row_hp), cycle - last_toggle);
          end
        end
        have_ref    = 1'b1;
        last_toggle = cycle;
      end
    end
    prev_note  = note_sel;
    prev_audio = audio_bits;
  end

  // ==============================
  // Row start and end
  // ==============================
  task automatic begin_row(input string name, input int half_period);
    row_name           = name;
    row_hp             = half_period;
    row_start_measured = measured;
  endtask

  task automatic end_row(input int kind, input int expect_value);
    int shown;
    int digit;
    int diff;
    shown = 0;
    for (int i = 5; i >= 0; i--)
    begin
      digit = digit_value(hex[i]);
      shown = (digit < 0 || shown < 0) ? -1 : shown * 16 + digit;
    end
    diff = shown - expect_value;
    if (kind == KIND_RESET && audio_bits != 8'h80)
    begin
      row_value_errors++;
      print_fail("audio_sample", "0x80", int'(audio_bits));
    end
    case (kind)
      KIND_NOTE:
      begin
        if (measured == row_start_measured)
        begin
          row_other_errors++;
          $display("%s: no audio half period was measured", row_name);
        end
      end
      KIND_UP:
      begin
        if (diff <= 0 || diff % int'(SPEED_STEP) != 0 || diff > int'(MAX_SPEED))
        begin
          row_value_errors++;
          print_fail("display", $sformatf("0x%0h plus steps of %0d", expect_value,
            int'(SPEED_STEP)), shown);
        end
      end
      KIND_RESET, KIND_EXACT:
      begin
        if (shown != expect_value)
        begin
          row_value_errors++;
          print_fail("display", $sformatf("0x%0h", expect_value), shown);
        end
      end
      default:
      begin
        row_other_errors++;
        $display("%s: unknown check kind %0d", row_name, kind);
      end
    endcase
  endtask

endmodule

/* tb/tb_basic_organ.sv */
`timescale 1ns/1ps

module tb_basic_organ;
  import organ_pkg::*;

  localparam int CLK_FREQ_HZ  = 50_000;
  localparam int REPEAT_TICKS = 4;
  localparam int DISPLAY_DIV  = 100;
  localparam int NUM_RANDOM   = 4;
  localparam int NUM_ROWS     = 13 + NUM_RANDOM;
  localparam int NOTE_HZ [8]  = '{523, 587, 659, 698, 783, 880, 987, 1046};

  localparam int KIND_RESET = 0;
  localparam int KIND_NOTE  = 1;
  localparam int KIND_UP    = 2;
  localparam int KIND_EXACT = 3;

  typedef enum int {ACT_NONE, ACT_UP, ACT_DOWN, ACT_CLEAR} key_act_t;

  logic          CLK_50M;
  logic          reset;
  logic [2:0]    key;
  note_sel_t     note_sel;
  audio_sample_t audio_sample;
  seg_t          hex [6];
  int            value_errors;
  int            other_errors;

  // ==============================
  // Stimulus table
  // ==============================
  string     row_name   [NUM_ROWS];
  note_sel_t row_note   [NUM_ROWS];
  key_act_t  row_act    [NUM_ROWS];
  int        row_hold   [NUM_ROWS];
  int        row_kind   [NUM_ROWS];
  int        row_expect [NUM_ROWS];
  int        row_hp     [NUM_ROWS];
  int        num_filled = 0;
  int        cycle_count = 0;
  int        timeout_limit = 0;

  basic_organ #(
    .CLK_FREQ_HZ  (CLK_FREQ_HZ),
    .REPEAT_TICKS (REPEAT_TICKS),
    .DISPLAY_DIV  (DISPLAY_DIV)
  ) u_dut (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .key          (key),
    .note_sel     (note_sel),
    .audio_sample (audio_sample),
    .hex0         (hex[0]),
    .hex1         (hex[1]),
    .hex2         (hex[2]),
    .hex3         (hex[3]),
    .hex4         (hex[4]),
    .hex5         (hex[5])
  );

  organ_checker u_chk (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .note_sel     (note_sel),
    .audio_sample (audio_sample),
    .hex          (hex),
    .value_errors (value_errors),
    .other_errors (other_errors)
  );

  task automatic add_row(input string name, input int note, input key_act_t act,
                         input int hold, input int kind, input int expect_value);
    row_name[num_filled]   = name;
    row_note[num_filled]   = note_sel_t'(note);
    row_act[num_filled]    = act;
    row_hold[num_filled]   = hold;
    row_kind[num_filled]   = kind;
    row_expect[num_filled] = expect_value;
    // Clock cycles per half tone period, truncated
    row_hp[num_filled]     = CLK_FREQ_HZ / (2 * NOTE_HZ[note]);
    num_filled++;
  endtask

  task automatic build_table();
    add_row("reset_state", 0, ACT_NONE, 10, KIND_RESET, 0);
    for (int n = 0; n < 8; n++)
      add_row($sformatf("note_%0d", n), n, ACT_NONE, 300, KIND_NOTE, 0);
    add_row("speed_up", 3, ACT_UP, 1000, KIND_UP, int'(DEFAULT_SAMPLE_COUNT));
    add_row("speed_reset", 3, ACT_CLEAR, 10, KIND_EXACT, int'(DEFAULT_SAMPLE_COUNT));
    // 125 windows, clamp is reached after 120
    add_row("saturate_down", 5, ACT_DOWN, 25000, KIND_EXACT,
            int'(DEFAULT_SAMPLE_COUNT) - int'(MAX_SPEED));
    add_row("speed_reset_again", 5, ACT_CLEAR, 10, KIND_EXACT, int'(DEFAULT_SAMPLE_COUNT));
    for (int i = 0; i < NUM_RANDOM; i++)
      add_row($sformatf("note_rand_%0d", i), int'($urandom_range(7, 0)), ACT_NONE, 300,
              KIND_NOTE, 0);
  endtask

  // Keys are active low
  function automatic logic [2:0] key_pattern(input key_act_t act);
    case (act)
      ACT_UP:    return 3'b110;
      ACT_DOWN:  return 3'b101;
      ACT_CLEAR: return 3'b011;
      default:   return 3'b111;
    endcase
  endfunction

  task automatic apply_row(input int r);
    @(negedge CLK_50M);
    note_sel = row_note[r];
    key      = key_pattern(row_act[r]);
    u_chk.begin_row(row_name[r], row_hp[r]);
    repeat (row_hold[r]) @(negedge CLK_50M);
    key = 3'b111;
    // Release through sync and speed update, then one full display update
    if (row_kind[r] == KIND_UP || row_kind[r] == KIND_EXACT)
      repeat (DISPLAY_DIV + 6) @(negedge CLK_50M);
    u_chk.end_row(row_kind[r], row_expect[r]);
  endtask

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  always @(posedge CLK_50M)
  begin
    cycle_count++;
    if (cycle_count > timeout_limit)
    begin
      $display("Run timed out after %0d cycles", cycle_count);
      $display("Test failures found");
      $finish;
    end
  end

  // ==============================
  // Main sequence
  // ==============================
  initial
  begin
    int hold_total;
    void'($urandom(73));
    reset    = 1'b1;
    key      = 3'b111;
    note_sel = '0;
    build_table();
    hold_total = 0;
    foreach (row_hold[r])
      hold_total += row_hold[r];
    timeout_limit = hold_total + 2000;
    repeat (2) @(posedge CLK_50M);
    @(negedge CLK_50M);
    reset = 1'b0;
    for (int r = 0; r < NUM_ROWS; r++)
      apply_row(r);
    $display("Error counts: value %0d, other %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

/* src.f */
common/organ_pkg.sv
common/ctrl_if.sv
decode/control_decode.sv
execute/tone_generator.sv
execute/speed_control.sv
result/display_driver.sv
hw/basic_organ.sv
tb/organ_checker.sv
tb/tb_basic_organ.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert
TOP       := tb_basic_organ
FILELIST  := src.f
LOG       := sim.log

SHELL := /bin/bash

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	set -o pipefail; ./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failures found" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
